//--- design/alu.sv
`timescale 1ns/100ps

module alu (
	input cpuPkg::ctrl_t ctrl,
	input cpuPkg::word_t yValue,
	input cpuPkg::word_t bus,
	output cpuPkg::word_t aluResult
);
	import cpuPkg::*;

	// Y holds the first operand, the bus carries the second.
	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluResult = yValue + bus;
			aluSub: aluResult = yValue - bus;
			aluAnd: aluResult = yValue & bus;
			aluOr: aluResult = yValue | bus;
			default: aluResult = bus; // Pass the bus through.
		endcase
	end

endmodule

//--- design/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	input logic clk,
	input logic reset,
	input cpuPkg::instr_t instr,
	output cpuPkg::ctrl_t ctrl,
	output logic halted
);
	import cpuPkg::*;

	typedef enum logic [2:0] {
		phaseT0, phaseT1, phaseT2, phaseT3, phaseT4, phaseT5, phaseHalted
	} phase_t;

	phase_t phase;
	aluOp_t opAlu;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= phaseT0; // Fetch starts in the first cycle after reset.
		end else begin
			case (phase)
				phaseT0: phase <= phaseT1;
				phaseT1: phase <= phaseT2;
				phaseT2: phase <= phaseT3;
				phaseT3: phase <= (instr.opcode == opHalt) ? phaseHalted : phaseT4;
				phaseT4: phase <= phaseT5;
				phaseT5: phase <= phaseT0;
				default: phase <= phaseHalted; // Only reset leaves this state.
			endcase
		end
	end

	assign halted = (phase == phaseHalted);

	always_comb begin
		case (instr.opcode)
			opSub: opAlu = aluSub;
			opAnd: opAlu = aluAnd;
			opOr: opAlu = aluOr;
			default: opAlu = aluAdd;
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (phase)
			phaseT0: begin
				ctrl.busSel = busPc;
				ctrl.marIn = 1'b1;
			end
			phaseT1: begin
				ctrl.mdrIn = 1'b1;
				ctrl.incPc = 1'b1;
			end
			phaseT2: begin
				ctrl.busSel = busMdr;
				ctrl.irIn = 1'b1;
			end
			phaseT3: begin
				case (instr.opcode)
					opAdd, opSub, opAnd, opOr, opAddi: begin
						ctrl.busSel = busReg;
						ctrl.regSel = fieldRb;
						ctrl.yIn = 1'b1;
					end
					opJal: begin
						// PC already points past the jal.
						ctrl.busSel = busPc;
						ctrl.regSel = fieldLink;
						ctrl.regIn = 1'b1;
					end
					opJr: begin
						ctrl.busSel = busReg;
						ctrl.regSel = fieldRa;
						ctrl.pcIn = 1'b1;
					end
					opOut: begin
						ctrl.busSel = busReg;
						ctrl.regSel = fieldRa;
						ctrl.outIn = 1'b1;
					end
					default: ;
				endcase
			end
			phaseT4: begin
				case (instr.opcode)
					opAdd, opSub, opAnd, opOr, opAddi: begin
						ctrl.busSel = (instr.opcode == opAddi) ? busImm : busReg;
						ctrl.regSel = fieldRc;
						ctrl.aluOp = opAlu;
						ctrl.zIn = 1'b1;
					end
					opJal: begin
						ctrl.busSel = busReg;
						ctrl.regSel = fieldRa;
						ctrl.pcIn = 1'b1;
					end
					default: ;
				endcase
			end
			phaseT5: begin
				if (instr.opcode inside {opAdd, opSub, opAnd, opOr, opAddi}) begin
					ctrl.busSel = busZ;
					ctrl.regSel = fieldRa;
					ctrl.regIn = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// The PC register in the datapath would get two conflicting updates.
	pcUpdateExclusive: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.pcIn && ctrl.incPc))
		else $error("pcIn and incPc asserted in the same cycle");

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int addrWidth = 8; // 256 words of RAM.
	localparam int regCount = 16;
	localparam int regIdxWidth = $clog2(regCount);
	localparam int linkReg = 15; // jal writes the return address here.

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [addrWidth-1:0] memAddr_t;

	typedef enum logic [4:0] {
		opAdd = 5'd0,
		opSub = 5'd1,
		opAnd = 5'd2,
		opOr = 5'd3,
		opAddi = 5'd4,
		opJal = 5'd5,
		opJr = 5'd6,
		opOut = 5'd7,
		opHalt = 5'd8
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [regIdxWidth-1:0] ra;
		logic [regIdxWidth-1:0] rb;
		logic [regIdxWidth-1:0] rc;
		logic [14:0] imm; // Sign-extended when it drives the bus.
	} instr_t;

	typedef enum logic [2:0] {busNone, busPc, busMdr, busReg, busZ, busImm} busSrc_t;
	typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOp_t;
	typedef enum logic [1:0] {fieldRa, fieldRb, fieldRc, fieldLink} regField_t;

	// One bundle from the control unit to every datapath block.
	typedef struct packed {
		busSrc_t busSel;
		logic marIn;
		logic mdrIn;
		logic irIn;
		logic pcIn;
		logic incPc;
		logic yIn;
		logic zIn;
		aluOp_t aluOp;
		logic regIn;
		regField_t regSel;
		logic outIn;
	} ctrl_t;

endpackage

//--- design/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
	input logic clk,
	input logic reset,
	input logic progWe,
	input cpuPkg::memAddr_t progAddr,
	input cpuPkg::word_t progData,
	output logic outStrobe,
	output cpuPkg::word_t outData,
	output logic halted
);
	import cpuPkg::*;

	ctrl_t ctrl;
	instr_t instr;
	word_t bus;
	word_t regData;
	word_t mdrData;
	word_t aluResult;
	word_t yValue;

	controlUnit control (
		.clk(clk), .reset(reset), .instr(instr), .ctrl(ctrl), .halted(halted)
	);

	registerFile regFile (
		.clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr), .bus(bus),
		.regData(regData)
	);

	specialRegisters specRegs (
		.clk(clk), .reset(reset), .ctrl(ctrl), .regData(regData),
		.mdrData(mdrData), .aluResult(aluResult), .bus(bus), .yValue(yValue),
		.instr(instr), .outStrobe(outStrobe), .outData(outData)
	);

	alu aluUnit (
		.ctrl(ctrl), .yValue(yValue), .bus(bus), .aluResult(aluResult)
	);

	memoryInterface memory (
		.clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus), .progWe(progWe),
		.progAddr(progAddr), .progData(progData), .mdrData(mdrData)
	);

endmodule

//--- design/memoryInterface.sv
`timescale 1ns/100ps

module memoryInterface (
	input logic clk,
	input logic reset,
	input cpuPkg::ctrl_t ctrl,
	input cpuPkg::word_t bus,
	input logic progWe,
	input cpuPkg::memAddr_t progAddr,
	input cpuPkg::word_t progData,
	output cpuPkg::word_t mdrData
);
	import cpuPkg::*;

	word_t ram [2**addrWidth];
	memAddr_t mar;

	always_ff @(posedge clk) begin
		if (reset) begin
			mar <= '0;
		end else if (ctrl.marIn) begin
			mar <= bus[addrWidth-1:0]; // Upper address bits are ignored.
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.mdrIn) begin
			mdrData <= ram[mar];
		end
	end

	// Program load port, the only write path into RAM.
	always_ff @(posedge clk) begin
		if (progWe) begin
			ram[progAddr] <= progData;
		end
	end

	// Loading while the CPU runs would race the instruction fetch.
	loadOnlyInReset: assert property (@(posedge clk) progWe |-> reset)
		else $error("progWe asserted while reset is low");

endmodule

//--- design/registerFile.sv
`timescale 1ns/100ps

module registerFile (
	input logic clk,
	input logic reset,
	input cpuPkg::ctrl_t ctrl,
	input cpuPkg::instr_t instr,
	input cpuPkg::word_t bus,
	output cpuPkg::word_t regData
);
	import cpuPkg::*;

	word_t regs [regCount];
	logic [regIdxWidth-1:0] regIndex;

	always_comb begin
		case (ctrl.regSel)
			fieldRa: regIndex = instr.ra;
			fieldRb: regIndex = instr.rb;
			fieldRc: regIndex = instr.rc;
			default: regIndex = regIdxWidth'(linkReg);
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regIn && regIndex != '0) begin
			regs[regIndex] <= bus; // R0 is never written.
		end
	end

	assign regData = (regIndex == '0) ? '0 : regs[regIndex];

endmodule

//--- design/specialRegisters.sv
`timescale 1ns/100ps

module specialRegisters (
	input logic clk,
	input logic reset,
	input cpuPkg::ctrl_t ctrl,
	input cpuPkg::word_t regData,
	input cpuPkg::word_t mdrData,
	input cpuPkg::word_t aluResult,
	output cpuPkg::word_t bus,
	output cpuPkg::word_t yValue,
	output cpuPkg::instr_t instr,
	output logic outStrobe,
	output cpuPkg::word_t outData
);
	import cpuPkg::*;

	word_t pc;
	word_t z;
	word_t immValue;

	assign immValue = {{(dataWidth - $bits(instr.imm)){instr.imm[$bits(instr.imm)-1]}}, instr.imm};

	always_comb begin
		case (ctrl.busSel)
			busPc: bus = pc;
			busMdr: bus = mdrData;
			busReg: bus = regData;
			busZ: bus = z;
			busImm: bus = immValue;
			default: bus = '0; // Nobody drives the bus.
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			instr <= '0;
			outStrobe <= 1'b0;
		end else begin
			if (ctrl.pcIn) begin
				pc <= bus;
			end else if (ctrl.incPc) begin
				pc <= pc + 1'b1; // Word addressed.
			end
			if (ctrl.irIn) begin
				instr <= instr_t'(bus);
			end
			outStrobe <= ctrl.outIn; // Strobe follows the load by one cycle.
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.yIn) yValue <= bus;
		if (ctrl.zIn) z <= aluResult;
		if (ctrl.outIn) outData <= bus;
	end

	// Back-to-back out instructions are six cycles apart at the closest.
	strobeOneCycle: assert property (@(posedge clk) disable iff (reset)
		outStrobe |=> !outStrobe)
		else $error("outStrobe held high for more than one cycle");

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpuTopTb -o cpuSim &&
./obj_dir/cpuSim | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" &&
echo "Simulation finished without errors." ||
{ echo "Simulation failed."; exit 1; }

//--- sim.f
design/cpuPkg.sv
design/controlUnit.sv
design/registerFile.sv
design/specialRegisters.sv
design/alu.sv
design/memoryInterface.sv
design/cpuTop.sv
tests/cpuTopTb.sv

//--- tests/cpuTopTb.sv
`timescale 1ns/100ps

module cpuTopTb #(
	parameter int clkPeriod = 40,
	parameter int resetCycles = 10,
	parameter int numEntries = 8,
	parameter int maxInstr = 12, // No program in the table runs more instructions.
	parameter int cyclesPerInstr = 6,
	parameter int postHaltCycles = 24
);
	import cpuPkg::*;

	logic clk;
	logic reset;
	logic progWe;
	memAddr_t progAddr;
	word_t progData;
	logic outStrobe;
	word_t outData;
	logic halted;

	word_t progWords [numEntries][8];
	word_t expectVals [numEntries][4];
	int expectCount [numEntries] = '{3, 2, 2, 2, 2, 1, 2, 2};
	int stopAfter [numEntries] = '{0, 0, 0, 0, 0, 0, 39, 0}; // Nonzero cuts the run by reset.
	word_t seen [$];

	cpuTop uut (
		.clk(clk), .reset(reset), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .outStrobe(outStrobe), .outData(outData), .halted(halted)
	);

	function automatic word_t instrWord(opcode_t op, int ra, int rb, int rc, int imm);
		instr_t i;
		i.opcode = op;
		i.ra = 4'(ra);
		i.rb = 4'(rb);
		i.rc = 4'(rc);
		i.imm = 15'(imm);
		return word_t'(i);
	endfunction

	task automatic checkValue(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Stopping at the first mismatch.");
		end
	endtask

	// Operand order for addi is Ra = Rb + imm, for R-type Ra = Rb op Rc.
	task automatic fillTable();
		progWords[0] = '{instrWord(opAddi, 1, 0, 0, 100), instrWord(opOut, 1, 0, 0, 0),
			instrWord(opAddi, 2, 0, 0, -5), instrWord(opOut, 2, 0, 0, 0),
			instrWord(opAddi, 3, 0, 0, -16384), instrWord(opOut, 3, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0)};
		expectVals[0] = '{32'd100, 32'hFFFF_FFFB, 32'hFFFF_C000, 32'd0};
		progWords[1] = '{instrWord(opAddi, 1, 0, 0, -1), instrWord(opAddi, 2, 0, 0, 3),
			instrWord(opAdd, 3, 1, 2, 0), instrWord(opOut, 3, 0, 0, 0),
			instrWord(opSub, 4, 3, 2, 0), instrWord(opOut, 4, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0)};
		expectVals[1] = '{32'd2, 32'hFFFF_FFFF, 32'd0, 32'd0}; // The sum wraps past 2^32.
		progWords[2] = '{instrWord(opAddi, 1, 0, 0, 32'h0F0F), instrWord(opAddi, 2, 0, 0, -256),
			instrWord(opAnd, 3, 1, 2, 0), instrWord(opOut, 3, 0, 0, 0),
			instrWord(opOr, 4, 1, 2, 0), instrWord(opOut, 4, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0)};
		expectVals[2] = '{32'h0000_0F00, 32'hFFFF_FF0F, 32'd0, 32'd0};
		// The jal at address 1 links 2 into R15 and skips the halt at address 2.
		progWords[3] = '{instrWord(opAddi, 1, 0, 0, 4), instrWord(opJal, 1, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0),
			instrWord(opOut, 15, 0, 0, 0), instrWord(opAddi, 2, 0, 0, 77),
			instrWord(opOut, 2, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0)};
		expectVals[3] = '{32'd2, 32'd77, 32'd0, 32'd0};
		// Subroutine at 5 prints 11 and returns to 3, which prints 22.
		progWords[4] = '{instrWord(opAddi, 2, 0, 0, 11), instrWord(opAddi, 1, 0, 0, 5),
			instrWord(opJal, 1, 0, 0, 0), instrWord(opOut, 3, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opOut, 2, 0, 0, 0),
			instrWord(opAddi, 3, 0, 0, 22), instrWord(opJr, 15, 0, 0, 0)};
		expectVals[4] = '{32'd11, 32'd22, 32'd0, 32'd0};
		progWords[5] = '{instrWord(opAddi, 1, 0, 0, 9), instrWord(opOut, 1, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opOut, 1, 0, 0, 0),
			instrWord(opOut, 1, 0, 0, 0), instrWord(opAddi, 1, 0, 0, 1),
			instrWord(opOut, 1, 0, 0, 0), instrWord(opOut, 1, 0, 0, 0)};
		expectVals[5] = '{32'd9, 32'd0, 32'd0, 32'd0};
		// Endless loop that prints 7 every twelve cycles until the next reset.
		// The reset lands while its third out is in T3.
		progWords[6] = '{instrWord(opAddi, 1, 0, 0, 7), instrWord(opAddi, 2, 0, 0, 2),
			instrWord(opOut, 1, 0, 0, 0), instrWord(opJr, 2, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0)};
		expectVals[6] = '{32'd7, 32'd7, 32'd0, 32'd0};
		progWords[7] = '{instrWord(opAddi, 5, 0, 0, -2), instrWord(opOut, 5, 0, 0, 0),
			instrWord(opOut, 1, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0),
			instrWord(opHalt, 0, 0, 0, 0), instrWord(opHalt, 0, 0, 0, 0)};
		expectVals[7] = '{32'hFFFF_FFFE, 32'd0, 32'd0, 32'd0}; // R1 was cleared by reset.
	endtask

	task automatic loadProgram(int e);
		for (int c = 0; c < resetCycles; c++) begin
			@(posedge clk);
			reset <= 1'b1;
			if (c < 8) begin
				progWe <= 1'b1;
				progAddr <= memAddr_t'(c);
				progData <= progWords[e][c];
			end else begin
				progWe <= 1'b0;
			end
			if (c == 1) begin
				// First cycle in which the DUT has seen reset.
				@(negedge clk);
				checkValue($sformatf("halted in reset before program %0d", e),
					word_t'(halted), 0);
				checkValue($sformatf("outStrobe in reset before program %0d", e),
					word_t'(outStrobe), 0);
			end
		end
		@(posedge clk);
		reset <= 1'b0;
		progWe <= 1'b0;
	endtask

	task automatic runProgram(int e);
		int cycles;
		bit done;
		seen.delete();
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (outStrobe) begin
				seen.push_back(outData);
			end
			cycles++;
			done = (stopAfter[e] != 0) ? (cycles >= stopAfter[e]) : halted;
		end
		if (stopAfter[e] == 0) begin
			repeat (postHaltCycles) begin
				@(negedge clk);
				checkValue("halted after halt", word_t'(halted), 1);
				checkValue("outStrobe after halt", word_t'(outStrobe), 0);
			end
		end
		checkValue($sformatf("output count of program %0d", e), seen.size(), expectCount[e]);
		for (int i = 0; i < seen.size(); i++) begin
			checkValue($sformatf("outData[%0d] of program %0d", i, e), seen[i], expectVals[e][i]);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(numEntries * (maxInstr * cyclesPerInstr + resetCycles + postHaltCycles + 4) * clkPeriod);
		$display("Timeout: the CPU never halted within the time allowed.");
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired.");
	end

	initial begin
		reset = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		fillTable();
		for (int e = 0; e < numEntries; e++) begin
			loadProgram(e);
			runProgram(e);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
